//--- dv/mmu_apb_mem.sv
`timescale 1ns/1ps
// read-only APB slave memory holding the page tables
// 4096 words of 64 bits at paddr[14:3], upper address bits are ignored
// 0 to 3 random wait states per transfer, pslverr at ERR_ADDR only
// clear_mem must be called before any write_word

module mmu_apb_mem
  import mmu_pkg::*;
#(
  parameter logic [31:0]     SEED     = 32'h1,
  parameter logic [PLEN-1:0] ERR_ADDR = '0
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  apb_req_t apb_i,
  output apb_rsp_t apb_o,
  output int       read_count_o
);

  logic [PTE_W-1:0] mem [4096];
  logic [11:0]      idx;
  logic [1:0]       wait_q;
  int               seed = SEED;
  int               reads;

  assign idx                = apb_i.paddr[14:3];
  assign apb_o.prdata       = mem[idx];
  assign apb_o.pready       = apb_i.psel && apb_i.penable && (wait_q == 2'd0);
  assign apb_o.pslverr      = apb_o.pready && (apb_i.paddr == ERR_ADDR);
  assign read_count_o       = reads;

  // unwritten words read back as invalid PTEs, v clear and word index in the PPN field
  task automatic clear_mem();
    for (int i = 0; i < 4096; i++) begin
      mem[i] = PTE_W'(i) << 10;
    end
  endtask

  task automatic write_word(input logic [PLEN-1:0] addr, input logic [PTE_W-1:0] data);
    mem[addr[14:3]] = data;
  endtask

  // --------------------------------------------------
  // wait-state counter, loaded in the setup phase
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_q <= 2'd0;
      reads  <= 0;
    end else begin
      if (apb_i.psel && !apb_i.penable) begin
        wait_q <= 2'($random(seed));
      end else if (apb_i.psel && apb_i.penable && wait_q != 2'd0) begin
        wait_q <= wait_q - 2'd1;
      end
      // one count per finished transfer, error or not
      if (apb_o.pready) begin
        reads <= reads + 1;
      end
    end
  end

endmodule

//--- dv/tb_mmu.sv
`timescale 1ns/1ps
// testbench for the Sv39 data MMU
// root, L1 and L0 tables at fixed bases with one request held per table entry
// each entry expects an exact APB read count of 1 per walked level

module tb_mmu
  import mmu_pkg::*;
();

  localparam int              CLK_PERIOD = 20;
  localparam logic [31:0]     SEED       = 32'hffae_be1a;
  localparam logic [PLEN-1:0] ROOT_BASE  = 56'h1000;
  localparam logic [PLEN-1:0] L1_BASE    = 56'h2000;
  localparam logic [PLEN-1:0] L0_BASE    = 56'h3000;
  // L0 entry 6 answers with a bus error
  localparam logic [PLEN-1:0] ERR_ADDR   = L0_BASE + 56'd48;
  localparam int              N_TESTS    = 24;
  localparam int              MAX_WAIT   = 100;
  localparam logic [7:0]      F_V        = 8'h01;
  localparam logic [7:0]      F_R        = 8'h02;
  localparam logic [7:0]      F_W        = 8'h04;
  localparam logic [7:0]      F_U        = 8'h10;
  localparam logic [7:0]      F_G        = 8'h20;
  localparam logic [7:0]      F_A        = 8'h40;
  localparam logic [7:0]      F_D        = 8'h80;
  localparam logic [7:0]      LEAF       = F_D | F_A | F_W | F_R | F_V;

  typedef struct packed {
    logic              en;
    priv_lvl_e         priv;
    logic              sum;
    logic [ASID_W-1:0] asid;
    logic              flush;
    logic [VLEN-1:0]   vaddr;
    logic              is_store;
    logic [PLEN-1:0]   paddr;
    exc_cause_e        cause;
    logic              exc;
    logic              hit;
    logic [3:0]        reads;
  } test_t;

  logic              clk_i;
  logic              rst_ni;
  logic              flush_i;
  logic              en_translation_i;
  priv_lvl_e         priv_lvl_i;
  logic              sum_i;
  logic [PPNW-1:0]   satp_ppn_i;
  logic [ASID_W-1:0] asid_i;
  lsu_req_t          lsu_req_i;
  logic              lsu_dtlb_hit_o;
  logic [PPNW-1:0]   lsu_dtlb_ppn_o;
  logic              lsu_valid_o;
  logic [PLEN-1:0]   lsu_paddr_o;
  mmu_exc_t          lsu_exception_o;
  apb_req_t          apb_req;
  apb_rsp_t          apb_rsp;
  int                read_count;

  test_t tests [N_TESTS];
  string names [N_TESTS];
  int    n_added;
  int    errors;
  int    passed;
  int    failed;

  mmu_top dut0 (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .en_translation_i (en_translation_i),
    .priv_lvl_i       (priv_lvl_i),
    .sum_i            (sum_i),
    .satp_ppn_i       (satp_ppn_i),
    .asid_i           (asid_i),
    .lsu_req_i        (lsu_req_i),
    .lsu_dtlb_hit_o   (lsu_dtlb_hit_o),
    .lsu_dtlb_ppn_o   (lsu_dtlb_ppn_o),
    .lsu_valid_o      (lsu_valid_o),
    .lsu_paddr_o      (lsu_paddr_o),
    .lsu_exception_o  (lsu_exception_o),
    .apb_o            (apb_req),
    .apb_i            (apb_rsp)
  );

  mmu_apb_mem #(
    .SEED     (SEED),
    .ERR_ADDR (ERR_ADDR)
  ) mem0 (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .apb_i        (apb_req),
    .apb_o        (apb_rsp),
    .read_count_o (read_count)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // --------------------------------------------------
  // page tables
  function automatic pte_t make_pte(input logic [PPNW-1:0] ppn, input logic [7:0] flags);
    pte_t p;
    p     = '0;
    p.ppn = ppn;
    {p.d, p.a, p.g, p.u, p.x, p.w, p.r, p.v} = flags;
    return p;
  endfunction

  task automatic build_tables();
    mem0.clear_mem();
    // root 0 points to L1 and root 1 is a 1G leaf
    mem0.write_word(ROOT_BASE, make_pte(L1_BASE[PLEN-1:PAGE_OFS], F_V));
    mem0.write_word(ROOT_BASE + 8, make_pte(44'h80000, LEAF));
    // L1 0 points to L0 and L1 1 is a 2M leaf
    mem0.write_word(L1_BASE, make_pte(L0_BASE[PLEN-1:PAGE_OFS], F_V));
    mem0.write_word(L1_BASE + 8, make_pte(44'h400, LEAF));
    // 4K leaves where entry 5 stays invalid and entry 6 is the bus error
    mem0.write_word(L0_BASE + 8, make_pte(44'h100, LEAF));
    mem0.write_word(L0_BASE + 16, make_pte(44'h101, LEAF | F_U));
    mem0.write_word(L0_BASE + 24, make_pte(44'h102, LEAF & ~F_W));
    mem0.write_word(L0_BASE + 32, make_pte(44'h103, LEAF & ~F_D));
    mem0.write_word(L0_BASE + 56, make_pte(44'h104, LEAF | F_G));
  endtask

  // --------------------------------------------------
  // stimulus table
  task automatic add_test(input string name, input logic en, input priv_lvl_e priv,
                          input logic sum, input logic [ASID_W-1:0] asid,
                          input logic flush, input logic [VLEN-1:0] vaddr,
                          input logic is_store, input logic [PLEN-1:0] paddr,
                          input exc_cause_e cause, input logic exc, input logic hit,
                          input int reads);
    test_t t;
    t.en       = en;
    t.priv     = priv;
    t.sum      = sum;
    t.asid     = asid;
    t.flush    = flush;
    t.vaddr    = vaddr;
    t.is_store = is_store;
    t.paddr    = paddr;
    t.cause    = cause;
    t.exc      = exc;
    t.hit      = hit;
    t.reads    = 4'(reads);
    tests[n_added] = t;
    names[n_added] = name;
    n_added++;
  endtask

  task automatic build_test_list();
    n_added = 0;
    add_test("bare load", 0, S, 0, 16'd1, 0, 39'h7f_1234_5678, 0,
             56'h7f_1234_5678, LOAD_PAGE_FAULT, 0, 1, 0);
    add_test("bare store", 0, S, 0, 16'd1, 0, 39'h3abc, 1,
             56'h3abc, STORE_PAGE_FAULT, 0, 1, 0);
    add_test("4k walk", 1, S, 0, 16'd1, 0, 39'h1abc, 0,
             56'h100abc, LOAD_PAGE_FAULT, 0, 1, 3);
    add_test("4k repeat", 1, S, 0, 16'd1, 0, 39'h1ff0, 0,
             56'h100ff0, LOAD_PAGE_FAULT, 0, 1, 0);
    add_test("2m walk", 1, S, 0, 16'd1, 0, 39'h22_3456, 0,
             56'h42_3456, LOAD_PAGE_FAULT, 0, 1, 2);
    add_test("2m repeat", 1, S, 0, 16'd1, 0, 39'h2f_f008, 0,
             56'h4f_f008, LOAD_PAGE_FAULT, 0, 1, 0);
    add_test("1g walk", 1, S, 0, 16'd1, 0, 39'h4123_4567, 0,
             56'h8123_4567, LOAD_PAGE_FAULT, 0, 1, 1);
    add_test("1g repeat", 1, S, 0, 16'd1, 0, 39'h7fff_fff8, 0,
             56'hbfff_fff8, LOAD_PAGE_FAULT, 0, 1, 0);
    add_test("u load s page", 1, U, 0, 16'd1, 0, 39'h1100, 0,
             56'h0, LOAD_PAGE_FAULT, 1, 1, 0);
    add_test("s load u page", 1, S, 0, 16'd1, 0, 39'h2010, 0,
             56'h0, LOAD_PAGE_FAULT, 1, 1, 3);
    add_test("s load u page sum", 1, S, 1, 16'd1, 0, 39'h2020, 0,
             56'h101020, LOAD_PAGE_FAULT, 0, 1, 0);
    add_test("store no w", 1, S, 0, 16'd1, 0, 39'h3040, 1,
             56'h0, STORE_PAGE_FAULT, 1, 1, 3);
    add_test("load no w", 1, S, 0, 16'd1, 0, 39'h3040, 0,
             56'h102040, LOAD_PAGE_FAULT, 0, 1, 0);
    add_test("store no d", 1, S, 0, 16'd1, 0, 39'h4008, 1,
             56'h0, STORE_PAGE_FAULT, 1, 1, 3);
    add_test("load no d", 1, S, 0, 16'd1, 0, 39'h4008, 0,
             56'h103008, LOAD_PAGE_FAULT, 0, 1, 0);
    add_test("invalid pte load", 1, S, 0, 16'd1, 0, 39'h5000, 0,
             56'h0, LOAD_PAGE_FAULT, 1, 0, 3);
    add_test("invalid pte store", 1, S, 0, 16'd1, 0, 39'h5678, 1,
             56'h0, STORE_PAGE_FAULT, 1, 0, 3);
    add_test("bus error load", 1, S, 0, 16'd1, 0, 39'h6000, 0,
             56'h0, LD_ACCESS_FAULT, 1, 0, 3);
    add_test("global walk", 1, S, 0, 16'd1, 0, 39'h7123, 0,
             56'h104123, LOAD_PAGE_FAULT, 0, 1, 3);
    add_test("asid 1 walk", 1, S, 0, 16'd1, 0, 39'h1200, 0,
             56'h100200, LOAD_PAGE_FAULT, 0, 1, 3);
    add_test("asid 2 rewalk", 1, S, 0, 16'd2, 0, 39'h1200, 0,
             56'h100200, LOAD_PAGE_FAULT, 0, 1, 3);
    add_test("asid 2 global hit", 1, S, 0, 16'd2, 0, 39'h7200, 0,
             56'h104200, LOAD_PAGE_FAULT, 0, 1, 0);
    add_test("flush global rewalk", 1, S, 0, 16'd2, 1, 39'h7300, 0,
             56'h104300, LOAD_PAGE_FAULT, 0, 1, 3);
    add_test("store after flush", 1, S, 0, 16'd2, 0, 39'h1300, 1,
             56'h100300, STORE_PAGE_FAULT, 0, 1, 3);
  endtask

  // --------------------------------------------------
  // compare tasks
  task automatic check_paddr(input logic [PLEN-1:0] got, input logic [PLEN-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: paddr %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_ppn(input logic [PPNW-1:0] got, input logic [PPNW-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: dtlb ppn %h, expected %h", $time, got, exp);
    end
  endtask

  // cause and tval only count when valid is set
  task automatic check_exc(input mmu_exc_t got, input mmu_exc_t exp);
    if (got.valid !== exp.valid
        || (exp.valid && (got.cause !== exp.cause || got.tval !== exp.tval))) begin
      errors++;
      $display("FAILED %0t: exception v=%b cause=%0d tval=%h, expected v=%b cause=%0d tval=%h",
               $time, got.valid, got.cause, got.tval, exp.valid, exp.cause, exp.tval);
    end
  endtask

  task automatic check_hit(input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: dtlb hit %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_reads(input int got, input int exp);
    if (got != exp) begin
      errors++;
      $display("FAILED %0t: %0d APB reads, expected %0d", $time, got, exp);
    end
  endtask

  // --------------------------------------------------
  // one table entry with the request held until lsu_valid_o
  task automatic run_test(input int idx);
    test_t    t;
    mmu_exc_t exp_exc;
    int       start_reads;
    int       cycles;
    int       errs_before;
    t           = tests[idx];
    errs_before = errors;
    cycles      = 0;
    if (t.flush) begin
      lsu_req_i = '0;
      flush_i   = 1'b1;
      @(negedge clk_i);
      flush_i   = 1'b0;
    end
    en_translation_i   = t.en;
    priv_lvl_i         = t.priv;
    sum_i              = t.sum;
    asid_i             = t.asid;
    start_reads        = read_count;
    lsu_req_i.req      = 1'b1;
    lsu_req_i.vaddr    = t.vaddr;
    lsu_req_i.is_store = t.is_store;
    @(negedge clk_i);
    while (!lsu_valid_o && cycles < MAX_WAIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!lsu_valid_o) begin
      errors++;
      $display("test %0d (%s): no response from the MMU within %0d cycles",
               idx, names[idx], MAX_WAIT);
    end else begin
      exp_exc.cause = t.cause;
      exp_exc.tval  = t.vaddr;
      exp_exc.valid = t.exc;
      check_exc(lsu_exception_o, exp_exc);
      // the address is meaningless on a fault
      if (!t.exc) begin
        check_paddr(lsu_paddr_o, t.paddr);
        // cycle-0 PPN of the request that is still held
        check_ppn(lsu_dtlb_ppn_o, t.paddr[PLEN-1:PAGE_OFS]);
      end
      check_hit(lsu_dtlb_hit_o, t.hit);
      check_reads(read_count - start_reads, int'(t.reads));
    end
    if (errors == errs_before) begin
      passed++;
      $display("test %0d (%s): ok", idx, names[idx]);
    end else begin
      failed++;
      $display("test %0d (%s): error", idx, names[idx]);
    end
  endtask

  // --------------------------------------------------
  // main sequence
  initial begin
    errors           = 0;
    passed           = 0;
    failed           = 0;
    rst_ni           = 1'b0;
    flush_i          = 1'b0;
    en_translation_i = 1'b0;
    priv_lvl_i       = S;
    sum_i            = 1'b0;
    satp_ppn_i       = ROOT_BASE[PLEN-1:PAGE_OFS];
    asid_i           = 16'd1;
    lsu_req_i        = '0;
    build_tables();
    build_test_list();
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    for (int i = 0; i < N_TESTS; i++) begin
      run_test(i);
    end
    lsu_req_i = '0;
    $display("%0d tests: %0d passed, %0d failed, %0d check errors",
             N_TESTS, passed, failed, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog allows 200 cycles per table entry
  initial begin
    #(N_TESTS * 200 * CLK_PERIOD);
    $display("run timed out after %0d cycles", N_TESTS * 200);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- hw/mmu_pkg.sv
// shared types for the Sv39 data-side MMU
// 64-bit PTEs, 56-bit physical and 39-bit virtual addresses
// only U and S privilege are decoded, M mode is not handled here

package mmu_pkg;

  // --------------------------------------------------
  // address and table geometry
  localparam int unsigned VLEN     = 39;
  localparam int unsigned PLEN     = 56;
  localparam int unsigned PPNW     = 44;
  localparam int unsigned PAGE_OFS = 12;
  localparam int unsigned VPN_W    = 9;
  localparam int unsigned LEVELS   = 3;
  localparam int unsigned PTE_W    = 64;
  localparam int unsigned ASID_W   = 16;

  typedef enum logic [1:0] {
    U = 2'b00,
    S = 2'b01
  } priv_lvl_e;

  // one layout for leaves and pointers
  typedef struct packed {
    logic [9:0]      reserved;
    logic [PPNW-1:0] ppn;
    logic [1:0]      rsw;
    logic            d;
    logic            a;
    logic            g;
    logic            u;
    logic            x;
    logic            w;
    logic            r;
    logic            v;
  } pte_t;

  // --------------------------------------------------
  // exceptions
  typedef enum logic [3:0] {
    LD_ACCESS_FAULT  = 4'd5,
    ST_ACCESS_FAULT  = 4'd7,
    LOAD_PAGE_FAULT  = 4'd13,
    STORE_PAGE_FAULT = 4'd15
  } exc_cause_e;

  typedef struct packed {
    exc_cause_e      cause;
    logic [VLEN-1:0] tval;
    logic            valid;
  } mmu_exc_t;

  // --------------------------------------------------
  // internal and port records
  typedef struct packed {
    logic                     valid;
    logic                     is_2m;
    logic                     is_1g;
    logic [VLEN-PAGE_OFS-1:0] vpn;
    logic [ASID_W-1:0]        asid;
    pte_t                     content;
  } tlb_update_t;

  typedef struct packed {
    logic            req;
    logic [VLEN-1:0] vaddr;
    logic            is_store;
  } lsu_req_t;

  // read-only master, pwrite stays low
  typedef struct packed {
    logic            psel;
    logic            penable;
    logic            pwrite;
    logic [PLEN-1:0] paddr;
  } apb_req_t;

  typedef struct packed {
    logic [PTE_W-1:0] prdata;
    logic             pready;
    logic             pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic            page_fault;
    logic            access_fault;
    logic [VLEN-1:0] vaddr;
  } walk_err_t;

endpackage

//--- hw/mmu_ptw.sv
`timescale 1ns/1ps
// Sv39 page-table walker with an APB master for PTE reads
// one walk at a time, misses seen while busy are ignored
// A and D bits are never written back, a clear A bit faults

module mmu_ptw
  import mmu_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              en_translation_i,
  input  logic [PPNW-1:0]   satp_ppn_i,
  input  logic [ASID_W-1:0] asid_i,
  input  lsu_req_t          req_i,
  input  logic              lu_hit_i,
  output apb_req_t          apb_o,
  input  apb_rsp_t          apb_i,
  output tlb_update_t       update_o,
  output logic              walk_done_o,
  output walk_err_t         walk_err_o
);

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS,
    ERR
  } state_e;

  state_e                      state_q, state_d;
  logic [$clog2(LEVELS)-1:0]   lvl_q;
  logic [PPNW-1:0]             ppn_q;
  logic [VLEN-1:0]             vaddr_q;
  logic [ASID_W-1:0]           asid_q;
  logic                        pf_q;
  logic                        af_q;
  logic [VPN_W-1:0]            vpn_sel;
  pte_t                        pte;
  logic                        rsp_ok;
  logic                        is_leaf;
  logic                        misaligned;
  logic                        pte_bad;
  logic                        last_lvl;

  // level 0 indexes with VPN[2]
  assign vpn_sel  = vaddr_q[PAGE_OFS + VPN_W * (LEVELS - 1 - lvl_q) +: VPN_W];
  assign last_lvl = (lvl_q == LEVELS - 1);
  assign pte      = pte_t'(apb_i.prdata);
  assign rsp_ok   = (state_q == ACCESS) && apb_i.pready;
  assign is_leaf  = pte.r || pte.x;

  // superpage PPN must be aligned to its page size
  always_comb begin
    misaligned = 1'b0;
    if (lvl_q == 0) begin
      misaligned = |pte.ppn[2*VPN_W-1:0];
    end else if (lvl_q == 1) begin
      misaligned = |pte.ppn[VPN_W-1:0];
    end
  end

  assign pte_bad = !pte.v || (pte.w && !pte.r)
                 || (is_leaf && (misaligned || !pte.a))
                 || (!is_leaf && last_lvl);

  // --------------------------------------------------
  // APB master, 8-byte PTE address from table PPN and VPN field
  assign apb_o.psel    = (state_q == SETUP) || (state_q == ACCESS);
  assign apb_o.penable = (state_q == ACCESS);
  assign apb_o.pwrite  = 1'b0;
  assign apb_o.paddr   = {ppn_q, vpn_sel, 3'b000};

  // refill goes out in the cycle the leaf is accepted
  assign update_o.valid   = rsp_ok && !apb_i.pslverr && !pte_bad && is_leaf;
  assign update_o.is_1g   = (lvl_q == 0);
  assign update_o.is_2m   = (lvl_q == 1);
  assign update_o.vpn     = vaddr_q[VLEN-1:PAGE_OFS];
  assign update_o.asid    = asid_q;
  assign update_o.content = pte;

  assign walk_done_o             = (state_q == ERR);
  assign walk_err_o.page_fault   = pf_q;
  assign walk_err_o.access_fault = af_q;
  assign walk_err_o.vaddr        = vaddr_q;

  // --------------------------------------------------
  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (en_translation_i && req_i.req && !lu_hit_i) begin
          state_d = SETUP;
        end
      end
      SETUP: state_d = ACCESS;
      ACCESS: begin
        if (rsp_ok) begin
          if (apb_i.pslverr || pte_bad) begin
            state_d = ERR;
          end else if (is_leaf) begin
            state_d = IDLE;
          end else begin
            state_d = SETUP;
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // walk context, latched at the miss and per level
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && state_d == SETUP) begin
      vaddr_q <= req_i.vaddr;
      asid_q  <= asid_i;
      ppn_q   <= satp_ppn_i;
      lvl_q   <= '0;
    end else if (rsp_ok && state_d == SETUP) begin
      // pointer, descend one level
      ppn_q <= pte.ppn;
      lvl_q <= lvl_q + 1'b1;
    end
    if (rsp_ok) begin
      af_q <= apb_i.pslverr;
      pf_q <= !apb_i.pslverr && pte_bad;
    end
  end

endmodule

//--- hw/mmu_resp_stage.sv
`timescale 1ns/1ps
// cycle-1 response stage that registers the lookup every cycle
// privilege level, SUM and translation enable are taken live in cycle 1
// with translation off the physical address is the zero-extended vaddr

module mmu_resp_stage
  import mmu_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            en_translation_i,
  input  priv_lvl_e       priv_lvl_i,
  input  logic            sum_i,
  input  lsu_req_t        req_i,
  input  logic            lu_hit_i,
  input  pte_t            lu_content_i,
  input  logic            lu_is_2m_i,
  input  logic            lu_is_1g_i,
  input  logic            walk_done_i,
  input  walk_err_t       walk_err_i,
  output logic            dtlb_hit_o,
  output logic [PPNW-1:0] dtlb_ppn_o,
  output logic            valid_o,
  output logic [PLEN-1:0] paddr_o,
  output mmu_exc_t        exception_o
);

  logic            req_q;
  logic            hit_q;
  logic            done_q;
  logic [VLEN-1:0] vaddr_q;
  logic            store_q;
  pte_t            pte_q;
  logic            is_2m_q;
  logic            is_1g_q;
  walk_err_t       err_q;
  logic            priv_err;

  // --------------------------------------------------
  // cycle 0 hit and PPN straight from the TLB
  assign dtlb_hit_o = en_translation_i ? lu_hit_i : 1'b1;

  always_comb begin
    dtlb_ppn_o = PPNW'(req_i.vaddr[VLEN-1:PAGE_OFS]);
    if (en_translation_i) begin
      dtlb_ppn_o = lu_content_i.ppn;
      if (lu_is_2m_i) begin
        dtlb_ppn_o[VPN_W-1:0] = req_i.vaddr[PAGE_OFS +: VPN_W];
      end
      if (lu_is_1g_i) begin
        dtlb_ppn_o[2*VPN_W-1:0] = req_i.vaddr[PAGE_OFS +: 2*VPN_W];
      end
    end
  end

  // --------------------------------------------------
  // pipeline registers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q  <= 1'b0;
      hit_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      req_q  <= req_i.req;
      hit_q  <= lu_hit_i;
      done_q <= walk_done_i;
    end
  end

  always_ff @(posedge clk_i) begin
    vaddr_q <= req_i.vaddr;
    store_q <= req_i.is_store;
    pte_q   <= lu_content_i;
    is_2m_q <= lu_is_2m_i;
    is_1g_q <= lu_is_1g_i;
    err_q   <= walk_err_i;
  end

  // U mode needs u set and S mode may touch user pages only with SUM
  assign priv_err = (priv_lvl_i == U && !pte_q.u)
                 || (priv_lvl_i == S && pte_q.u && !sum_i);

  // --------------------------------------------------
  // cycle 1 address and exception
  always_comb begin
    paddr_o     = PLEN'(vaddr_q);
    valid_o     = req_q;
    exception_o = '0;
    if (en_translation_i) begin
      valid_o = (req_q && hit_q) || done_q;
      paddr_o = {pte_q.ppn, vaddr_q[PAGE_OFS-1:0]};
      // superpages pass the low VPN fields through
      if (is_2m_q) begin
        paddr_o[PAGE_OFS +: VPN_W] = vaddr_q[PAGE_OFS +: VPN_W];
      end
      if (is_1g_q) begin
        paddr_o[PAGE_OFS +: 2*VPN_W] = vaddr_q[PAGE_OFS +: 2*VPN_W];
      end
      if (done_q) begin
        exception_o.valid = err_q.page_fault || err_q.access_fault;
        exception_o.tval  = err_q.vaddr;
        if (err_q.access_fault) begin
          exception_o.cause = store_q ? ST_ACCESS_FAULT : LD_ACCESS_FAULT;
        end else begin
          exception_o.cause = store_q ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
        end
      end else if (req_q && hit_q) begin
        exception_o.tval = vaddr_q;
        if (store_q) begin
          exception_o.cause = STORE_PAGE_FAULT;
          exception_o.valid = !pte_q.w || !pte_q.d || priv_err;
        end else begin
          exception_o.cause = LOAD_PAGE_FAULT;
          exception_o.valid = !pte_q.r || priv_err;
        end
      end
    end
  end

endmodule

//--- hw/mmu_tlb.sv
`timescale 1ns/1ps
// fully associative data TLB for 4K, 2M and 1G pages
// lookup is combinational, refill and flush act on the clock edge
// a flush in the same cycle as a refill drops the refill
// TLB_ENTRIES must be 2 or more

module mmu_tlb
  import mmu_pkg::*;
#(
  parameter int unsigned TLB_ENTRIES = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  input  logic              lu_access_i,
  input  logic [VLEN-1:0]   lu_vaddr_i,
  input  logic [ASID_W-1:0] lu_asid_i,
  input  tlb_update_t       update_i,
  output logic              lu_hit_o,
  output pte_t              lu_content_o,
  output logic              lu_is_2m_o,
  output logic              lu_is_1g_o
);

  localparam int unsigned PTR_W = $clog2(TLB_ENTRIES);

  typedef struct packed {
    logic [ASID_W-1:0] asid;
    logic [VPN_W-1:0]  vpn2;
    logic [VPN_W-1:0]  vpn1;
    logic [VPN_W-1:0]  vpn0;
    logic              is_2m;
    logic              is_1g;
    logic              g;
  } tag_t;

  logic [TLB_ENTRIES-1:0] valid_q;
  tag_t                   tags_q    [TLB_ENTRIES];
  pte_t                   content_q [TLB_ENTRIES];
  logic [PTR_W-1:0]       rr_q;
  logic [VPN_W-1:0]       lu_vpn2;
  logic [VPN_W-1:0]       lu_vpn1;
  logic [VPN_W-1:0]       lu_vpn0;
  logic [TLB_ENTRIES-1:0] match;

  assign lu_vpn0 = lu_vaddr_i[PAGE_OFS +: VPN_W];
  assign lu_vpn1 = lu_vaddr_i[PAGE_OFS + VPN_W +: VPN_W];
  assign lu_vpn2 = lu_vaddr_i[PAGE_OFS + 2 * VPN_W +: VPN_W];

  // --------------------------------------------------
  // lookup
  always_comb begin
    lu_hit_o     = 1'b0;
    lu_content_o = '0;
    lu_is_2m_o   = 1'b0;
    lu_is_1g_o   = 1'b0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      // global pages ignore the ASID
      // lower VPN fields are don't-care for superpages
      match[i] = lu_access_i && valid_q[i]
               && (tags_q[i].g || tags_q[i].asid == lu_asid_i)
               && tags_q[i].vpn2 == lu_vpn2
               && (tags_q[i].is_1g || tags_q[i].vpn1 == lu_vpn1)
               && (tags_q[i].is_1g || tags_q[i].is_2m || tags_q[i].vpn0 == lu_vpn0);
      if (match[i]) begin
        lu_hit_o     = 1'b1;
        lu_content_o = content_q[i];
        lu_is_2m_o   = tags_q[i].is_2m;
        lu_is_1g_o   = tags_q[i].is_1g;
      end
    end
  end

  // --------------------------------------------------
  // valid bits and round-robin victim pointer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      rr_q    <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (update_i.valid) begin
      valid_q[rr_q] <= 1'b1;
      // wrap at the last entry, count need not be a power of two
      rr_q <= (rr_q == PTR_W'(TLB_ENTRIES - 1)) ? '0 : rr_q + 1'b1;
    end
  end

  // tag and PTE storage
  always_ff @(posedge clk_i) begin
    if (update_i.valid && !flush_i) begin
      tags_q[rr_q].asid  <= update_i.asid;
      tags_q[rr_q].vpn2  <= update_i.vpn[2*VPN_W +: VPN_W];
      tags_q[rr_q].vpn1  <= update_i.vpn[VPN_W +: VPN_W];
      tags_q[rr_q].vpn0  <= update_i.vpn[0 +: VPN_W];
      tags_q[rr_q].is_2m <= update_i.is_2m;
      tags_q[rr_q].is_1g <= update_i.is_1g;
      tags_q[rr_q].g     <= update_i.content.g;
      content_q[rr_q]    <= update_i.content;
    end
  end

endmodule

//--- hw/mmu_top.sv
`timescale 1ns/1ps
// Sv39 data MMU top, TLB plus walker plus response stage
// the LSU holds its request until lsu_valid_o

module mmu_top
  import mmu_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  input  logic              en_translation_i,
  input  priv_lvl_e         priv_lvl_i,
  input  logic              sum_i,
  input  logic [PPNW-1:0]   satp_ppn_i,
  input  logic [ASID_W-1:0] asid_i,
  input  lsu_req_t          lsu_req_i,
  output logic              lsu_dtlb_hit_o,
  output logic [PPNW-1:0]   lsu_dtlb_ppn_o,
  output logic              lsu_valid_o,
  output logic [PLEN-1:0]   lsu_paddr_o,
  output mmu_exc_t          lsu_exception_o,
  output apb_req_t          apb_o,
  input  apb_rsp_t          apb_i
);

  localparam int unsigned DTLB_ENTRIES = 4;

  logic        lu_hit;
  pte_t        lu_content;
  logic        lu_is_2m;
  logic        lu_is_1g;
  tlb_update_t tlb_update;
  logic        walk_done;
  walk_err_t   walk_err;

  mmu_tlb #(
    .TLB_ENTRIES(DTLB_ENTRIES)
  ) dtlb0 (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .lu_access_i  (lsu_req_i.req),
    .lu_vaddr_i   (lsu_req_i.vaddr),
    .lu_asid_i    (asid_i),
    .update_i     (tlb_update),
    .lu_hit_o     (lu_hit),
    .lu_content_o (lu_content),
    .lu_is_2m_o   (lu_is_2m),
    .lu_is_1g_o   (lu_is_1g)
  );

  mmu_ptw ptw0 (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .en_translation_i (en_translation_i),
    .satp_ppn_i       (satp_ppn_i),
    .asid_i           (asid_i),
    .req_i            (lsu_req_i),
    .lu_hit_i         (lu_hit),
    .apb_o            (apb_o),
    .apb_i            (apb_i),
    .update_o         (tlb_update),
    .walk_done_o      (walk_done),
    .walk_err_o       (walk_err)
  );

  mmu_resp_stage resp0 (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .en_translation_i (en_translation_i),
    .priv_lvl_i       (priv_lvl_i),
    .sum_i            (sum_i),
    .req_i            (lsu_req_i),
    .lu_hit_i         (lu_hit),
    .lu_content_i     (lu_content),
    .lu_is_2m_i       (lu_is_2m),
    .lu_is_1g_i       (lu_is_1g),
    .walk_done_i      (walk_done),
    .walk_err_i       (walk_err),
    .dtlb_hit_o       (lsu_dtlb_hit_o),
    .dtlb_ppn_o       (lsu_dtlb_ppn_o),
    .valid_o          (lsu_valid_o),
    .paddr_o          (lsu_paddr_o),
    .exception_o      (lsu_exception_o)
  );

endmodule

//--- project.f
hw/mmu_pkg.sv
hw/mmu_tlb.sv
hw/mmu_ptw.sv
hw/mmu_resp_stage.sv
hw/mmu_top.sv
dv/mmu_apb_mem.sv
dv/tb_mmu.sv
